//--- common/sd_host_pkg.sv
// Host-internal state encodings and SPI clock ratio.
// sclk_half must be at least 1 and fit the 8-bit divider counter.
package sd_host_pkg;

  // Command sequencer
  typedef enum logic [2:0] {
    IDLE,
    SEND,
    RESPONSE,
    DATA,
    FINISH
  } ctrl_state_e;

  // Response and data receiver
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT_START,
    RX_RECEIVE
  } rx_state_e;

  // Clock cycles per sclk half period
  localparam int sclk_half = 2;

endpackage

//--- common/sd_proto_pkg.sv
// SD card SPI-mode protocol constants shared by host and card model.
// Only CMD0, CMD8, CMD13, CMD17 and CMD58 are covered. Single-block reads only.
package sd_proto_pkg;

  // Supported command indexes
  typedef enum logic [5:0] {
    CMD0  = 6'd0,
    CMD8  = 6'd8,
    CMD13 = 6'd13,
    CMD17 = 6'd17,
    CMD58 = 6'd58
  } cmd_e;

  // Response formats the receiver can collect
  typedef enum logic [2:0] {
    RESP_R1   = 3'd0,
    RESP_R3R7 = 3'd1,
    RESP_R2   = 3'd2,
    RESP_DATA = 3'd3
  } resp_e;

  // Lengths on the wire, in bits
  localparam int frame_bits = 48;
  localparam int r1_bits    = 8;
  localparam int r3r7_bits  = 40;
  localparam int r2_bits    = 16;
  localparam int block_bits = 512;
  localparam int crc16_bits = 16;

  // Stored response is sized for R3/R7
  localparam int resp_bits = 40;

  // x^7 + x^3 + 1 and x^16 + x^12 + x^5 + 1, top term implied
  localparam logic [6:0]  crc7_poly  = 7'h09;
  localparam logic [15:0] crc16_poly = 16'h1021;

endpackage

//--- hdl/sd_host_ctrl.sv
// Command sequencer: send frame, collect response, then the data block for CMD17.
// A start is taken only while busy is low. Response type comes from the command.
`timescale 1ns/10ps

module sd_host_ctrl (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                start,
  input  logic [5:0]                          cmd_index,
  input  logic [31:0]                         argument,
  input  logic                                tx_done,
  input  logic                                rx_done,
  input  logic [sd_proto_pkg::block_bits-1:0] received_data,
  input  logic                                rx_crc_error,
  output logic                                clk_enable,
  output logic                                cs_n,
  output logic                                tx_start,
  output logic [5:0]                          command,
  output logic [31:0]                         tx_argument,
  output logic                                rx_start,
  output sd_proto_pkg::resp_e                 response_type,
  output logic                                busy,
  output logic                                done,
  output logic [sd_proto_pkg::resp_bits-1:0]  response,
  output logic [sd_proto_pkg::block_bits-1:0] read_data,
  output logic                                crc_error
);

  sd_host_pkg::ctrl_state_e state;
  sd_proto_pkg::cmd_e       cmd_q;
  logic                     read_accepted;

  function automatic sd_proto_pkg::resp_e resp_for(input sd_proto_pkg::cmd_e cmd);
    case (cmd)
      sd_proto_pkg::CMD8, sd_proto_pkg::CMD58: resp_for = sd_proto_pkg::RESP_R3R7;
      sd_proto_pkg::CMD13:                     resp_for = sd_proto_pkg::RESP_R2;
      default:                                 resp_for = sd_proto_pkg::RESP_R1;
    endcase
  endfunction

  // Block follows only a clean R1 to CMD17
  assign read_accepted = (cmd_q == sd_proto_pkg::CMD17) && (received_data[7:0] == 8'h00);

  assign command = cmd_q;
  assign busy    = (state != sd_host_pkg::IDLE) && (state != sd_host_pkg::FINISH);
  assign done    = (state == sd_host_pkg::FINISH);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state         <= sd_host_pkg::IDLE;
      cmd_q         <= sd_proto_pkg::CMD0;
      response_type <= sd_proto_pkg::RESP_R1;
      cs_n          <= 1'b1;
      clk_enable    <= 1'b0;
      tx_start      <= 1'b0;
      rx_start      <= 1'b0;
      crc_error     <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      rx_start <= 1'b0;
      case (state)
        sd_host_pkg::IDLE, sd_host_pkg::FINISH: begin
          state <= sd_host_pkg::IDLE;
          if (start) begin
            cmd_q         <= sd_proto_pkg::cmd_e'(cmd_index);
            response_type <= resp_for(sd_proto_pkg::cmd_e'(cmd_index));
            crc_error     <= 1'b0;
            cs_n          <= 1'b0;
            clk_enable    <= 1'b1;
            tx_start      <= 1'b1;
            state         <= sd_host_pkg::SEND;
          end
        end
        sd_host_pkg::SEND: begin
          if (tx_done) begin
            rx_start <= 1'b1;
            state    <= sd_host_pkg::RESPONSE;
          end
        end
        sd_host_pkg::RESPONSE: begin
          if (rx_done && read_accepted) begin
            response_type <= sd_proto_pkg::RESP_DATA;
            rx_start      <= 1'b1;
            state         <= sd_host_pkg::DATA;
          end else if (rx_done) begin
            cs_n       <= 1'b1;
            clk_enable <= 1'b0;
            state      <= sd_host_pkg::FINISH;
          end
        end
        sd_host_pkg::DATA: begin
          if (rx_done) begin
            crc_error  <= rx_crc_error;
            cs_n       <= 1'b1;
            clk_enable <= 1'b0;
            state      <= sd_host_pkg::FINISH;
          end
        end
        default: state <= sd_host_pkg::IDLE;
      endcase
    end
  end

  // Results and argument
  always_ff @(posedge clock) begin
    if (!busy && start) begin
      tx_argument <= argument;
    end
    if (state == sd_host_pkg::RESPONSE && rx_done) begin
      response <= received_data[sd_proto_pkg::resp_bits-1:0];
    end
    if (state == sd_host_pkg::DATA && rx_done) begin
      read_data <= received_data;
    end
  end

  done_after_deselect: assert property (@(posedge clock) disable iff (reset)
    done |-> cs_n);

endmodule

//--- hdl/sd_spi_clock.sv
// SPI clock divider. sclk idles high, so the first edge after enable is falling.
// Strobes are registered and line up with the cycle in which sclk changes.
`timescale 1ns/10ps

module sd_spi_clock (
  input  logic clock,
  input  logic reset,
  input  logic clk_enable,
  output logic sclk,
  output logic sample_strobe,
  output logic shift_strobe
);

  logic [7:0] half_count;
  logic       half_end;

  assign half_end = (half_count == 8'(sd_host_pkg::sclk_half - 1));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      half_count    <= '0;
      sclk          <= 1'b1;
      sample_strobe <= 1'b0;
      shift_strobe  <= 1'b0;
    end else begin
      sample_strobe <= clk_enable && half_end && !sclk;
      shift_strobe  <= clk_enable && half_end && sclk;
      if (!clk_enable) begin
        // Realign so each transaction starts from the same phase
        half_count <= '0;
        sclk       <= 1'b1;
      end else if (half_end) begin
        half_count <= '0;
        sclk       <= !sclk;
      end else begin
        half_count <= half_count + 8'd1;
      end
    end
  end

  // Every sclk edge while running carries its own strobe and only that one
  strobe_marks_edge: assert property (@(posedge clock) disable iff (reset)
    $past(clk_enable) && (sclk != $past(sclk)) |->
      (sclk ? (sample_strobe && !shift_strobe) : (shift_strobe && !sample_strobe)));

endmodule

//--- hdl/sd_spi_host.sv
// SPI-mode SD host top level. One command at a time; wait for busy low.
// No write, busy wait or multi-block support.
`timescale 1ns/10ps

module sd_spi_host (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                start,
  input  logic [5:0]                          cmd_index,
  input  logic [31:0]                         argument,
  output logic                                busy,
  output logic                                done,
  output logic [sd_proto_pkg::resp_bits-1:0]  response,
  output logic [sd_proto_pkg::block_bits-1:0] read_data,
  output logic                                crc_error,
  output logic                                sclk,
  output logic                                cs_n,
  output logic                                mosi,
  input  logic                                miso
);

  logic                                clk_enable;
  logic                                sample_strobe;
  logic                                shift_strobe;
  logic                                tx_start;
  logic                                tx_done;
  logic [5:0]                          command;
  logic [31:0]                         tx_argument;
  logic                                rx_start;
  logic                                rx_done;
  logic                                rx_crc_error;
  sd_proto_pkg::resp_e                 response_type;
  logic [sd_proto_pkg::block_bits-1:0] received_data;

  sd_host_ctrl u_ctrl (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .cmd_index     (cmd_index),
    .argument      (argument),
    .tx_done       (tx_done),
    .rx_done       (rx_done),
    .received_data (received_data),
    .rx_crc_error  (rx_crc_error),
    .clk_enable    (clk_enable),
    .cs_n          (cs_n),
    .tx_start      (tx_start),
    .command       (command),
    .tx_argument   (tx_argument),
    .rx_start      (rx_start),
    .response_type (response_type),
    .busy          (busy),
    .done          (done),
    .response      (response),
    .read_data     (read_data),
    .crc_error     (crc_error)
  );

  sd_spi_clock u_clock (
    .clock         (clock),
    .reset         (reset),
    .clk_enable    (clk_enable),
    .sclk          (sclk),
    .sample_strobe (sample_strobe),
    .shift_strobe  (shift_strobe)
  );

  sd_transmitter u_tx (
    .clock         (clock),
    .reset         (reset),
    .tx_start      (tx_start),
    .command       (command),
    .argument      (tx_argument),
    .shift_strobe  (shift_strobe),
    .sample_strobe (sample_strobe),
    .mosi          (mosi),
    .tx_done       (tx_done)
  );

  sd_receiver u_rx (
    .clock         (clock),
    .reset         (reset),
    .rx_start      (rx_start),
    .response_type (response_type),
    .sample_strobe (sample_strobe),
    .miso          (miso),
    .received_data (received_data),
    .rx_done       (rx_done),
    .crc_error     (rx_crc_error)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SD host testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_sd_spi_host \
  -f sd_spi_host.f -o tb_sd_spi_host
output=$(./obj_dir/tb_sd_spi_host)
echo "$output"
if grep -qxF '** PASS **' <<< "$output"; then
  exit 0
fi
exit 1

//--- sd_receiver/sd_receiver.sv
// Serial receiver for R1, R3/R7, R2 and a single data block.
// The wait for the card's first zero bit is unbounded; no timeout.
// Responses arrive right-aligned in received_data.
`timescale 1ns/10ps

module sd_receiver (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                rx_start,
  input  sd_proto_pkg::resp_e                 response_type,
  input  logic                                sample_strobe,
  input  logic                                miso,
  output logic [sd_proto_pkg::block_bits-1:0] received_data,
  output logic                                rx_done,
  output logic                                crc_error
);

  sd_host_pkg::rx_state_e state;
  sd_proto_pkg::resp_e    rx_type;

  // Bits still to come, counting down to the final one
  logic [9:0]  bits_left;
  logic [15:0] crc16;
  logic        crc_feedback;
  logic        is_data;
  logic        store_bit;

  assign is_data      = (rx_type == sd_proto_pkg::RESP_DATA);
  assign crc_feedback = crc16[15] ^ miso;
  // Data register holds still while the CRC field goes past
  assign store_bit    = !is_data || (bits_left > 10'(sd_proto_pkg::crc16_bits));

  function automatic logic [9:0] resp_length(input sd_proto_pkg::resp_e kind);
    case (kind)
      sd_proto_pkg::RESP_R3R7: resp_length = 10'(sd_proto_pkg::r3r7_bits);
      sd_proto_pkg::RESP_R2:   resp_length = 10'(sd_proto_pkg::r2_bits);
      default:                 resp_length = 10'(sd_proto_pkg::r1_bits);
    endcase
  endfunction

  // Shift register is cleared per transfer so short responses sit right-aligned
  always_ff @(posedge clock) begin
    if (rx_start) begin
      received_data <= '0;
    end else if (sample_strobe) begin
      if (state == sd_host_pkg::RX_WAIT_START && !miso && !is_data) begin
        received_data <= {received_data[sd_proto_pkg::block_bits-2:0], miso};
      end else if (state == sd_host_pkg::RX_RECEIVE && store_bit) begin
        received_data <= {received_data[sd_proto_pkg::block_bits-2:0], miso};
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= sd_host_pkg::RX_IDLE;
      rx_type   <= sd_proto_pkg::RESP_R1;
      bits_left <= '0;
      crc16     <= '0;
      rx_done   <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        sd_host_pkg::RX_IDLE: begin
          if (rx_start) begin
            rx_type <= response_type;
            crc16   <= '0;
            state   <= sd_host_pkg::RX_WAIT_START;
          end
        end
        sd_host_pkg::RX_WAIT_START: begin
          if (sample_strobe && !miso) begin
            // Token zero is dropped; a response's start bit is its first bit
            if (is_data) begin
              bits_left <= 10'(sd_proto_pkg::block_bits + sd_proto_pkg::crc16_bits);
            end else begin
              bits_left <= resp_length(rx_type) - 10'd1;
            end
            state <= sd_host_pkg::RX_RECEIVE;
          end
        end
        sd_host_pkg::RX_RECEIVE: begin
          if (sample_strobe) begin
            if (is_data) begin
              crc16 <= {crc16[14:0], 1'b0} ^
                       (crc_feedback ? sd_proto_pkg::crc16_poly : 16'd0);
            end
            bits_left <= bits_left - 10'd1;
            if (bits_left == 10'd1) begin
              rx_done <= 1'b1;
              state   <= sd_host_pkg::RX_IDLE;
            end
          end
        end
        default: state <= sd_host_pkg::RX_IDLE;
      endcase
    end
  end

  // Remainder over data plus CRC must be zero
  assign crc_error = rx_done && is_data && (crc16 != 16'd0);

  start_only_when_idle: assert property (@(posedge clock) disable iff (reset)
    rx_start |-> state == sd_host_pkg::RX_IDLE);

endmodule

//--- sd_spi_host.f
common/sd_proto_pkg.sv
common/sd_host_pkg.sv
hdl/sd_spi_clock.sv
sd_transmitter/sd_transmitter.sv
sd_receiver/sd_receiver.sv
hdl/sd_host_ctrl.sv
hdl/sd_spi_host.sv
sim/sd_card_model.sv
sim/tb_sd_spi_host.sv

//--- sd_transmitter/sd_transmitter.sv
// Command frame transmitter with CRC7. mosi changes only on shift_strobe
// and rests high between frames. command and argument are taken on tx_start.
`timescale 1ns/10ps

module sd_transmitter (
  input  logic        clock,
  input  logic        reset,
  input  logic        tx_start,
  input  logic [5:0]  command,
  input  logic [31:0] argument,
  input  logic        shift_strobe,
  input  logic        sample_strobe,
  output logic        mosi,
  output logic        tx_done
);

  // Start bit, transmission bit, index and argument
  logic [39:0] shift_reg;
  logic [6:0]  crc7;
  logic [5:0]  bit_count;
  logic        active;
  logic        in_payload;
  logic        in_crc;
  logic        crc_feedback;

  assign in_payload   = (bit_count < 6'd40);
  assign in_crc       = (bit_count < 6'(sd_proto_pkg::frame_bits - 1)) && !in_payload;
  assign crc_feedback = crc7[6] ^ shift_reg[39];

  // Frame payload and CRC, loaded fresh for every command
  always_ff @(posedge clock) begin
    if (tx_start) begin
      shift_reg <= {2'b01, command, argument};
      crc7      <= '0;
    end else if (active && shift_strobe) begin
      if (in_payload) begin
        shift_reg <= {shift_reg[38:0], 1'b0};
        crc7      <= {crc7[5:0], 1'b0} ^ (crc_feedback ? sd_proto_pkg::crc7_poly : 7'd0);
      end else if (in_crc) begin
        crc7 <= {crc7[5:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      active    <= 1'b0;
      bit_count <= '0;
      mosi      <= 1'b1;
      tx_done   <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (tx_start) begin
        active    <= 1'b1;
        bit_count <= '0;
      end else if (active) begin
        if (shift_strobe && bit_count != 6'(sd_proto_pkg::frame_bits)) begin
          bit_count <= bit_count + 6'd1;
          if (in_payload) begin
            mosi <= shift_reg[39];
          end else if (in_crc) begin
            mosi <= crc7[6];
          end else begin
            // Stop bit
            mosi <= 1'b1;
          end
        end else if (sample_strobe && bit_count == 6'(sd_proto_pkg::frame_bits)) begin
          // Last bit has been sampled by the card
          active  <= 1'b0;
          tx_done <= 1'b1;
          mosi    <= 1'b1;
        end
      end
    end
  end

  no_start_mid_frame: assert property (@(posedge clock) disable iff (reset)
    tx_start |-> !active);

endmodule

//--- sim/sd_card_model.sv
// Behavioural SPI-mode SD card for the host testbench. Takes mosi on rising sclk,
// drives miso on falling sclk. Answer content comes from the testbench inputs.
`timescale 1ns/10ps

module sd_card_model (
  input  logic                                sclk,
  input  logic                                cs_n,
  input  logic                                mosi,
  output logic                                miso,
  input  logic [5:0]                          expect_cmd,
  input  logic [31:0]                         expect_arg,
  input  logic [sd_proto_pkg::resp_bits-1:0]  resp_value,
  input  logic [5:0]                          resp_len,
  input  logic [7:0]                          delay_bytes,
  input  logic [sd_proto_pkg::block_bits-1:0] block,
  input  logic                                corrupt_crc,
  output logic                                frame_done,
  output logic                                frame_good
);

  logic [47:0] frame;
  int          rx_count = 0;
  // Bits still to go out on miso, oldest first
  logic        out_q[$];

  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] crc;
    int         i;
    crc = '0;
    for (i = 39; i >= 0; i--) begin
      if (crc[6] ^ bits[i]) begin
        crc = {crc[5:0], 1'b0} ^ sd_proto_pkg::crc7_poly;
      end else begin
        crc = {crc[5:0], 1'b0};
      end
    end
    return crc;
  endfunction

  function automatic logic [15:0] crc16_of(input logic [sd_proto_pkg::block_bits-1:0] bits);
    logic [15:0] crc;
    int          i;
    crc = '0;
    for (i = sd_proto_pkg::block_bits - 1; i >= 0; i--) begin
      if (crc[15] ^ bits[i]) begin
        crc = {crc[14:0], 1'b0} ^ sd_proto_pkg::crc16_poly;
      end else begin
        crc = {crc[14:0], 1'b0};
      end
    end
    return crc;
  endfunction

  // MSB first
  task automatic push_bits(input logic [sd_proto_pkg::block_bits-1:0] value, input int count);
    int i;
    for (i = count - 1; i >= 0; i--) begin
      out_q.push_back(value[i]);
    end
  endtask

  task automatic answer_frame();
    logic [15:0] data_crc;
    frame_good <= (frame[47:46] == 2'b01) && (frame[45:40] == expect_cmd) &&
                  (frame[39:8] == expect_arg) && (frame[7:1] == crc7_of(frame[47:8])) &&
                  frame[0];
    frame_done <= 1'b1;
    push_bits('1, 8 * int'(delay_bytes));
    push_bits(512'(resp_value), int'(resp_len));
    if (frame[45:40] == sd_proto_pkg::CMD17 && resp_value[7:0] == 8'h00) begin
      data_crc = crc16_of(block) ^ (corrupt_crc ? 16'h0001 : 16'h0000);
      // One idle byte, then the start token
      push_bits(512'(8'hff), 8);
      push_bits(512'(8'hfe), 8);
      push_bits(block, sd_proto_pkg::block_bits);
      push_bits(512'(data_crc), sd_proto_pkg::crc16_bits);
    end
  endtask

  always @(posedge sclk or negedge sclk or posedge cs_n) begin
    if (cs_n !== 1'b0) begin
      rx_count = 0;
      out_q.delete();
      miso <= 1'b1;
    end else if (sclk) begin
      if (rx_count < sd_proto_pkg::frame_bits) begin
        if (rx_count == 0) begin
          frame_done <= 1'b0;
          frame_good <= 1'b0;
        end
        frame    = {frame[46:0], mosi};
        rx_count = rx_count + 1;
        if (rx_count == sd_proto_pkg::frame_bits) begin
          answer_frame();
        end
      end
    end else if (out_q.size() > 0) begin
      miso <= out_q.pop_front();
    end else begin
      miso <= 1'b1;
    end
  end

endmodule

//--- sim/sd_patterns.txt
# cmd argument response delay_bytes data_seed corrupt_crc busy_start exp_block exp_crc_error
# All hex. response is right-aligned; delay_bytes of 0xff come before it.
00 00000000 0000000001 1 00000000 0 0 0 0
08 000001aa 01000001aa 2 00000000 0 0 0 0
3a 00000000 00c0ff8000 1 00000000 0 0 0 0
0d 00000000 0000000000 3 00000000 0 0 0 0
11 00000000 0000000000 1 00000000 0 0 1 0
11 00000200 0000000000 2 a5a5a5a5 1 0 1 1
11 00000400 0000000005 1 00000000 0 0 0 0
0d 12345678 0000000104 0 00000000 0 0 0 0
00 00000000 0000000001 1 00000000 0 1 0 0
11 00000600 0000000000 0 3c3c0f0f 0 1 1 0
08 00000155 0100000155 4 00000000 0 0 0 0
3a 00000000 0080ff8000 0 00000000 0 1 0 0
0d 00000000 0000000020 2 00000000 0 0 0 0
11 00000800 0000000004 3 00000000 0 1 0 0

//--- sim/tb_sd_spi_host.sv
// Testbench for the SPI-mode SD host. Run from the project root so that
// sim/sd_patterns.txt is found. read_data is compared only once a block was read.
`timescale 1ns/10ps

module tb_sd_spi_host;

  localparam int max_tests   = 32;
  localparam int block_words = sd_proto_pkg::block_bits / 32;

  logic                                clock;
  logic                                reset;
  logic                                start;
  logic [5:0]                          cmd_index;
  logic [31:0]                         argument;
  logic                                busy;
  logic                                done;
  logic [sd_proto_pkg::resp_bits-1:0]  response;
  logic [sd_proto_pkg::block_bits-1:0] read_data;
  logic                                crc_error;
  logic                                sclk;
  logic                                cs_n;
  logic                                mosi;
  logic                                miso;

  // What the card is told for the running test
  logic [5:0]                          card_cmd;
  logic [31:0]                         card_arg;
  logic [39:0]                         card_resp;
  logic [5:0]                          card_resp_len;
  logic [7:0]                          card_delay;
  logic [sd_proto_pkg::block_bits-1:0] card_block;
  logic                                card_corrupt;
  logic                                frame_done;
  logic                                frame_good;

  logic [5:0]  pat_cmd     [max_tests];
  logic [31:0] pat_arg     [max_tests];
  logic [39:0] pat_resp    [max_tests];
  logic [7:0]  pat_delay   [max_tests];
  logic [31:0] pat_seed    [max_tests];
  logic        pat_corrupt [max_tests];
  logic        pat_poke    [max_tests];
  logic        pat_block   [max_tests];
  logic        pat_crc     [max_tests];

  int                                  num_tests = 0;
  int                                  errors = 0;
  int                                  failed_tests = 0;
  int                                  cycle_count = 0;
  int                                  cycle_limit = 0;
  logic [sd_proto_pkg::block_bits-1:0] expected_block;
  logic                                have_block;

  sd_spi_host u_dut (
    .clock     (clock),
    .reset     (reset),
    .start     (start),
    .cmd_index (cmd_index),
    .argument  (argument),
    .busy      (busy),
    .done      (done),
    .response  (response),
    .read_data (read_data),
    .crc_error (crc_error),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  sd_card_model u_card (
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .expect_cmd  (card_cmd),
    .expect_arg  (card_arg),
    .resp_value  (card_resp),
    .resp_len    (card_resp_len),
    .delay_bytes (card_delay),
    .block       (card_block),
    .corrupt_crc (card_corrupt),
    .frame_done  (frame_done),
    .frame_good  (frame_good)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  // Response length by command, as the SD spec assigns it
  function automatic int resp_length_of(input logic [5:0] cmd);
    case (cmd)
      sd_proto_pkg::CMD8, sd_proto_pkg::CMD58: return sd_proto_pkg::r3r7_bits;
      sd_proto_pkg::CMD13:                     return sd_proto_pkg::r2_bits;
      default:                                 return sd_proto_pkg::r1_bits;
    endcase
  endfunction

  function automatic int wire_bits_of(input int n);
    int bits;
    bits = sd_proto_pkg::frame_bits + 8 * int'(pat_delay[n]) + resp_length_of(pat_cmd[n]);
    if (pat_cmd[n] == sd_proto_pkg::CMD17 && pat_resp[n][7:0] == 8'h00) begin
      // Gap byte, token, block and CRC16
      bits = bits + 16 + sd_proto_pkg::block_bits + sd_proto_pkg::crc16_bits;
    end
    return bits;
  endfunction

  task automatic read_patterns();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f_cmd, f_arg, f_delay, f_seed, f_corrupt, f_poke, f_block, f_crc;
    logic [39:0] f_resp;
    fd = $fopen("sim/sd_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open sim/sd_patterns.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && num_tests < max_tests) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_cmd, f_arg, f_resp, f_delay,
                         f_seed, f_corrupt, f_poke, f_block, f_crc);
        if (fields == 9) begin
          pat_cmd[num_tests]     = f_cmd[5:0];
          pat_arg[num_tests]     = f_arg;
          pat_resp[num_tests]    = f_resp;
          pat_delay[num_tests]   = f_delay[7:0];
          pat_seed[num_tests]    = f_seed;
          pat_corrupt[num_tests] = f_corrupt[0];
          pat_poke[num_tests]    = f_poke[0];
          pat_block[num_tests]   = f_block[0];
          pat_crc[num_tests]     = f_crc[0];
          num_tests++;
        end
      end
    end
    $fclose(fd);
    if (num_tests == 0) begin
      $display("No test patterns were read");
      errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [511:0] got,
                             input logic [511:0] expected);
    assert (got === expected) else begin
      $display("** Error: %s is %0h, expected %0h", name, got, expected);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    assert (got === expected) else begin
      $display("** Error: %s is %h, expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic check_idle();
    check_bit("cs_n", cs_n, 1'b1);
    check_bit("mosi", mosi, 1'b1);
  endtask

  task automatic run_test(input int n);
    int          errors_before;
    int          len;
    int          w;
    logic [39:0] mask;
    logic        saw_busy;
    errors_before = errors;
    len  = resp_length_of(pat_cmd[n]);
    mask = (40'd1 << len) - 40'd1;
    for (w = 0; w < block_words; w++) begin
      card_block[w*32 +: 32] = $urandom ^ pat_seed[n];
    end
    card_cmd      = pat_cmd[n];
    card_arg      = pat_arg[n];
    card_resp     = pat_resp[n];
    card_resp_len = 6'(len);
    card_delay    = pat_delay[n];
    card_corrupt  = pat_corrupt[n];
    check_idle();

    @(posedge clock);
    #1;
    start     = 1'b1;
    cmd_index = pat_cmd[n];
    argument  = pat_arg[n];
    @(posedge clock);
    #1;
    start    = 1'b0;
    saw_busy = busy;
    if (pat_poke[n]) begin
      // Competing command while the first is still running
      repeat (10) @(posedge clock);
      #1;
      start     = 1'b1;
      cmd_index = sd_proto_pkg::CMD8;
      argument  = '1;
      @(posedge clock);
      #1;
      start = 1'b0;
    end
    while (!done) begin
      @(posedge clock);
      #1;
    end

    check_bit("busy before done", saw_busy, 1'b1);
    check_bit("busy", busy, 1'b0);
    check_bit("cs_n", cs_n, 1'b1);
    assert (frame_done && frame_good) else begin
      $display("Test %0d: the card saw a malformed or unexpected command frame", n);
      errors++;
    end
    check_value("response", 512'(response), 512'(pat_resp[n] & mask));
    if (pat_block[n]) begin
      expected_block = card_block;
      have_block     = 1'b1;
    end
    if (have_block) begin
      check_value("read_data", read_data, expected_block);
    end
    check_bit("crc_error", crc_error, pat_crc[n]);
    @(posedge clock);
    #1;
    check_idle();

    if (errors == errors_before) begin
      $display("Test %0d CMD%0d arg %h: ok", n, pat_cmd[n], pat_arg[n]);
    end else begin
      $display("Test %0d CMD%0d arg %h: failed", n, pat_cmd[n], pat_arg[n]);
      failed_tests++;
    end
  endtask

  initial begin
    int n;
    void'($urandom(12));
    reset          = 1'b1;
    start          = 1'b0;
    cmd_index      = '0;
    argument       = '0;
    card_cmd       = '0;
    card_arg       = '0;
    card_resp      = '0;
    card_resp_len  = 6'd8;
    card_delay     = '0;
    card_block     = '0;
    card_corrupt   = 1'b0;
    expected_block = '0;
    have_block     = 1'b0;
    read_patterns();
    // Wire time of every test plus slack for the handshakes
    for (n = 0; n < num_tests; n++) begin
      cycle_limit = cycle_limit + wire_bits_of(n) * 2 * sd_host_pkg::sclk_half + 64;
    end
    cycle_limit = cycle_limit + 8 + 16;

    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    check_bit("crc_error", crc_error, 1'b0);
    check_bit("sclk", sclk, 1'b1);
    check_idle();
    $display("Reset state checked, %0d errors", errors);

    for (n = 0; n < num_tests; n++) begin
      run_test(n);
    end

    $display("Tests run %0d, failed %0d, errors %0d", num_tests, failed_tests, errors);
    if (errors == 0 && num_tests > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
